/* filelist.f */
logic/sprite_pkg.sv
logic/oam_scanner.sv
logic/sprite_addr_gen.sv
logic/pattern_rom.sv
logic/sprite_manager.sv
logic/sprite_unit_chain.sv
logic/sprite_engine.sv
bench/sprite_engine_tb.sv

/* Makefile */
VERILATOR = verilator
FLAGS = --timing --assert -Wno-fatal
TOP = sprite_engine_tb
FILELIST = filelist.f
OBJ_DIR = obj_dir
PASS_MSG = TESTBENCH PASSED

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^$(PASS_MSG)$$"

clean:
	rm -rf $(OBJ_DIR)

/* bench/sprite_engine_tb.sv */
// Sprite engine testbench with LFSR stimulus, reference pixel model and checking assertions
`timescale 1ns/1ns
`default_nettype none

module sprite_engine_tb;

	localparam int MAX_SPRITES = 8;
	localparam int OAM_ENTRIES = 64;
	localparam int IDX_W = $clog2(OAM_ENTRIES);
	localparam int LINES = 14; // Line starts issued below, the restart counting twice
	localparam int CYCLE_LIMIT = LINES * (OAM_ENTRIES + MAX_SPRITES * 12 + 300) * 2;
	localparam logic [31:0] SEED = 32'h126f3056;

	logic clock = 1'b0;
	logic reset_l;
	logic start;
	logic [7:0] row;
	logic oam_write;
	logic [IDX_W-1:0] oam_waddr;
	logic [sprite_pkg::OAM_W-1:0] oam_wdata;
	logic [7:0] pixel_x;
	logic ready, pixel_opaque, pixel_fg;
	logic [sprite_pkg::PIXEL_W-1:0] pixel_index;
	logic [sprite_pkg::PALETTE_W-1:0] pixel_palette;

	logic [31:0] oam_copy [OAM_ENTRIES];
	logic [31:0] lfsr_state;
	logic [7:0] model_row;
	logic started, pending, checking;
	logic exp_opaque, exp_fg;
	logic [sprite_pkg::PIXEL_W-1:0] exp_index;
	logic [sprite_pkg::PALETTE_W-1:0] exp_palette;
	int cycle_count = 0;

	sprite_engine #(
		.MAX_SPRITES_PER_LINE(MAX_SPRITES),
		.OAM_ENTRIES(OAM_ENTRIES)
	) uut (
		.clock(clock),
		.reset_l(reset_l),
		.start(start),
		.row(row),
		.oam_write(oam_write),
		.oam_waddr(oam_waddr),
		.oam_wdata(oam_wdata),
		.pixel_x(pixel_x),
		.ready(ready),
		.pixel_opaque(pixel_opaque),
		.pixel_index(pixel_index),
		.pixel_palette(pixel_palette),
		.pixel_fg(pixel_fg)
	);

	always #20 clock = ~clock;

	task automatic fail_check(input string msg);
		$display("%s", msg);
		$display("TESTBENCH FAILED");
		$fatal(1);
	endtask

	always @(posedge clock) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count > CYCLE_LIMIT) begin
			fail_check("Timeout: the run exceeded its cycle limit");
		end
	end

	// Taps for x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
	endfunction

	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr_state = lfsr_step(lfsr_state);
			v = {v[30:0], lfsr_state[0]};
		end
		return v;
	endfunction

	function automatic logic [31:0] make_entry(input logic [7:0] y, input logic [7:0] x,
			input logic [1:0] w, input logic x_mirror, input logic y_mirror);
		logic [31:0] e;
		e = rand_bits(32); // Tile, palette and priority stay random
		e[sprite_pkg::OAM_Y_POS +: 8] = y;
		e[sprite_pkg::OAM_X_POS +: 8] = x;
		e[sprite_pkg::OAM_W_POS +: 2] = w;
		e[sprite_pkg::OAM_XMIR_BIT] = x_mirror;
		e[sprite_pkg::OAM_YMIR_BIT] = y_mirror;
		return e;
	endfunction

	function automatic logic [31:0] random_sprite(input logic [7:0] r, input logic [7:0] x);
		return make_entry(r - 8'(rand_bits(3)), x, 2'(rand_bits(2)), 1'(rand_bits(1)),
			1'(rand_bits(1)));
	endfunction

	task automatic write_entry(input int idx, input logic [31:0] data);
		@(negedge clock);
		oam_write = 1'b1;
		oam_waddr = IDX_W'(idx);
		oam_wdata = data;
		oam_copy[idx] = data;
	endtask

	// Every entry lands at least 16 rows away from r
	task automatic fill_oam(input logic [7:0] r);
		for (int i = 0; i < OAM_ENTRIES; i++) begin
			write_entry(i, make_entry(r + 8'd16 + 8'(rand_bits(7)), 8'(rand_bits(8)),
				2'(rand_bits(2)), 1'(rand_bits(1)), 1'(rand_bits(1))));
		end
	endtask

	task automatic begin_line(input logic [7:0] r);
		@(negedge clock);
		oam_write = 1'b0;
		start = 1'b1;
		row = r;
		model_row = r;
		started = 1'b1;
		pending = 1'b1;
		@(negedge clock);
		start = 1'b0;
	endtask

	task automatic wait_ready;
		do begin
			@(negedge clock);
		end while (!ready);
		pending = 1'b0;
	endtask

	task automatic model_pixel(input logic [7:0] x);
		logic [31:0] e;
		logic [7:0] line;
		logic [2:0] fline;
		logic [8:0] dx;
		logic [5:0] span;
		logic [4:0] pos;
		logic [3:0] nibble, pix;
		int kept;
		kept = 0;
		exp_opaque = 1'b0;
		exp_index = '0;
		exp_palette = '0;
		exp_fg = 1'b0;
		for (int i = 0; i < OAM_ENTRIES; i++) begin
			e = oam_copy[i];
			line = model_row - e[sprite_pkg::OAM_Y_POS +: 8];
			if (line < 8'd8 && kept < MAX_SPRITES) begin
				kept++;
				dx = {1'b0, x} - {1'b0, e[sprite_pkg::OAM_X_POS +: 8]};
				span = 6'd8 * (6'(e[sprite_pkg::OAM_W_POS +: 2]) + 6'd1);
				if (!exp_opaque && dx < 9'(span)) begin
					// X mirror reverses the whole span, so columns swap too
					pos = e[sprite_pkg::OAM_XMIR_BIT] ? 5'(span - 6'd1 - 6'(dx)) : 5'(dx);
					fline = e[sprite_pkg::OAM_YMIR_BIT] ? 3'd7 - line[2:0] : line[2:0];
					nibble = {pos[3], fline}; // Low address nibble is column LSB and line
					pix = nibble * 4'd3 + {1'b0, pos[2:0]};
					if (pix != 4'd0) begin
						exp_opaque = 1'b1;
						exp_index = pix;
						exp_palette = e[sprite_pkg::OAM_PAL_POS +: sprite_pkg::PALETTE_W];
						exp_fg = e[sprite_pkg::OAM_FG_BIT];
					end
				end
			end
		end
	endtask

	task automatic sweep_pixels;
		for (int x = 0; x < 256; x++) begin
			@(negedge clock);
			pixel_x = 8'(x);
			model_pixel(8'(x));
			checking = 1'b1;
		end
		@(negedge clock);
		checking = 1'b0;
	endtask

	task automatic run_line(input logic [7:0] r);
		begin_line(r);
		wait_ready;
		sweep_pixels;
	endtask

	assert property (@(negedge clock) disable iff (!reset_l) !started |-> !ready && !pixel_opaque)
		else fail_check("Ready or an opaque pixel showed up before the first start");
	assert property (@(negedge clock) disable iff (!reset_l) ready |-> pending)
		else fail_check("A ready pulse came without a start waiting for it");
	assert property (@(negedge clock) disable iff (!reset_l) ready |=> !ready)
		else fail_check("Ready stayed high for more than one cycle");

	assert property (@(negedge clock) checking |-> pixel_opaque == exp_opaque)
		else fail_check($sformatf("FAILED pixel_opaque at x %h: got %h expected %h",
			$sampled(pixel_x), $sampled(pixel_opaque), $sampled(exp_opaque)));
	assert property (@(negedge clock) checking |-> pixel_index == exp_index)
		else fail_check($sformatf("FAILED pixel_index at x %h: got %h expected %h",
			$sampled(pixel_x), $sampled(pixel_index), $sampled(exp_index)));
	assert property (@(negedge clock) checking |-> pixel_palette == exp_palette)
		else fail_check($sformatf("FAILED pixel_palette at x %h: got %h expected %h",
			$sampled(pixel_x), $sampled(pixel_palette), $sampled(exp_palette)));
	assert property (@(negedge clock) checking |-> pixel_fg == exp_fg)
		else fail_check($sformatf("FAILED pixel_fg at x %h: got %h expected %h",
			$sampled(pixel_x), $sampled(pixel_fg), $sampled(exp_fg)));

	initial begin
		logic [7:0] r;
		logic [7:0] base_x;
		reset_l = 1'b0;
		start = 1'b0;
		row = '0;
		oam_write = 1'b0;
		oam_waddr = '0;
		oam_wdata = '0;
		pixel_x = '0;
		model_row = '0;
		started = 1'b0;
		pending = 1'b0;
		checking = 1'b0;
		exp_opaque = 1'b0;
		exp_index = '0;
		exp_palette = '0;
		exp_fg = 1'b0;
		lfsr_state = SEED;
		repeat (4) @(negedge clock);
		reset_l = 1'b1;

		for (int x = 0; x < 64; x++) begin
			@(negedge clock);
			pixel_x = 8'(x * 4); // Empty chain must stay transparent
		end

		for (int w = 0; w < 4; w++) begin
			r = 8'(rand_bits(8));
			fill_oam(r);
			write_entry(int'(rand_bits(IDX_W)),
				make_entry(r - 8'(rand_bits(3)), 8'(rand_bits(7)), 2'(w), 1'b0, 1'b0));
			run_line(r);
		end

		for (int m = 0; m < 4; m++) begin
			r = 8'(rand_bits(8));
			fill_oam(r);
			write_entry(int'(rand_bits(IDX_W)), make_entry(r - 8'(rand_bits(3)),
				8'(rand_bits(7)), 2'(rand_bits(2)), 1'(m), 1'(m >> 1)));
			run_line(r);
		end

		// Overlapping sprites at ascending OAM indices
		r = 8'(rand_bits(8));
		base_x = 8'(rand_bits(7)) + 8'd20;
		fill_oam(r);
		for (int i = 0; i < 4; i++) begin
			write_entry(3 + i * 11, random_sprite(r, base_x + 8'(rand_bits(4))));
		end
		run_line(r);

		r = 8'(rand_bits(8));
		fill_oam(r);
		for (int i = 0; i < MAX_SPRITES + 4; i++) begin
			write_entry((i * 5) % OAM_ENTRIES, random_sprite(r, 8'(rand_bits(8))));
		end
		run_line(r);

		// Dense lines, about half of all entries cover the row
		for (int n = 0; n < 2; n++) begin
			r = 8'(rand_bits(8));
			for (int i = 0; i < OAM_ENTRIES; i++) begin
				write_entry(i, make_entry(r - 8'(rand_bits(4)), 8'(rand_bits(8)),
					2'(rand_bits(2)), 1'(rand_bits(1)), 1'(rand_bits(1))));
			end
			run_line(r);
		end

		// Restart while the first line is still fetching
		r = 8'(rand_bits(8));
		fill_oam(r);
		for (int i = 0; i < 3; i++) begin
			write_entry(2 + i * 7, random_sprite(r, 8'(rand_bits(8))));
			write_entry(5 + i * 7, random_sprite(r + 8'd100, 8'(rand_bits(8))));
		end
		begin_line(r);
		repeat (20) @(negedge clock);
		begin_line(r + 8'd100);
		wait_ready;
		sweep_pixels;

		$display("TESTBENCH PASSED");
		$finish;
	end

endmodule

`default_nettype wire

/* logic/sprite_engine.sv */
// Sprite engine top level joining scanner, manager, pattern memory and slots
`timescale 1ns/1ns
`default_nettype none

module sprite_engine #(
	parameter int MAX_SPRITES_PER_LINE = 8,
	parameter int OAM_ENTRIES = 64
) (
	input  logic clock,
	input  logic reset_l,
	input  logic start,
	input  logic [7:0] row,
	input  logic oam_write,
	input  logic [$clog2(OAM_ENTRIES)-1:0] oam_waddr,
	input  logic [sprite_pkg::OAM_W-1:0] oam_wdata,
	input  logic [7:0] pixel_x,
	output logic ready,
	output logic pixel_opaque,
	output logic [sprite_pkg::PIXEL_W-1:0] pixel_index,
	output logic [sprite_pkg::PALETTE_W-1:0] pixel_palette,
	output logic pixel_fg
);

	logic conf_exists, conf_ack, conf_req;
	logic [7:0] conf_y, conf_x, conf_tile;
	logic [sprite_pkg::PALETTE_W-1:0] conf_palette;
	logic [1:0] conf_w;
	logic conf_x_mirror, conf_y_mirror, conf_fg_prio;

	logic pattern_read, pattern_avail;
	logic [sprite_pkg::ADDR_W-1:0] pattern_addr;
	logic [sprite_pkg::PATTERN_W-1:0] pattern_data;

	logic sprite_valid, sprite_ack;
	logic [7:0] sprite_x;
	logic [sprite_pkg::PALETTE_W-1:0] sprite_palette;
	logic [1:0] sprite_w;
	logic sprite_x_mirror, sprite_fg_prio;
	logic [3:0][sprite_pkg::PATTERN_W-1:0] sprite_pat;

	oam_scanner #(
		.OAM_ENTRIES(OAM_ENTRIES)
	) u_scanner (
		.clock(clock),
		.reset_l(reset_l),
		.clear(start),
		.row(row),
		.oam_write(oam_write),
		.oam_waddr(oam_waddr),
		.oam_wdata(oam_wdata),
		.conf_req(conf_req),
		.conf_exists(conf_exists),
		.conf_ack(conf_ack),
		.conf_y(conf_y),
		.conf_x(conf_x),
		.conf_tile(conf_tile),
		.conf_palette(conf_palette),
		.conf_w(conf_w),
		.conf_x_mirror(conf_x_mirror),
		.conf_y_mirror(conf_y_mirror),
		.conf_fg_prio(conf_fg_prio)
	);

	sprite_manager #(
		.MAX_SPRITES_PER_LINE(MAX_SPRITES_PER_LINE)
	) u_manager (
		.clock(clock),
		.reset_l(reset_l),
		.clear(start),
		.row(row),
		.conf_y(conf_y),
		.conf_x(conf_x),
		.conf_tile(conf_tile),
		.conf_palette(conf_palette),
		.conf_w(conf_w),
		.conf_x_mirror(conf_x_mirror),
		.conf_y_mirror(conf_y_mirror),
		.conf_fg_prio(conf_fg_prio),
		.conf_exists(conf_exists),
		.conf_ack(conf_ack),
		.pattern_avail(pattern_avail),
		.pattern_data(pattern_data),
		.sprite_ack(sprite_ack),
		.ready(ready),
		.conf_req(conf_req),
		.pattern_read(pattern_read),
		.pattern_addr(pattern_addr),
		.sprite_valid(sprite_valid),
		.sprite_x(sprite_x),
		.sprite_palette(sprite_palette),
		.sprite_w(sprite_w),
		.sprite_x_mirror(sprite_x_mirror),
		.sprite_fg_prio(sprite_fg_prio),
		.sprite_pat(sprite_pat)
	);

	pattern_rom u_rom (
		.clock(clock),
		.reset_l(reset_l),
		.pattern_read(pattern_read),
		.pattern_addr(pattern_addr),
		.pattern_avail(pattern_avail),
		.pattern_data(pattern_data)
	);

	sprite_unit_chain #(
		.MAX_SPRITES_PER_LINE(MAX_SPRITES_PER_LINE)
	) u_chain (
		.clock(clock),
		.reset_l(reset_l),
		.clear(start),
		.sprite_valid(sprite_valid),
		.sprite_x(sprite_x),
		.sprite_palette(sprite_palette),
		.sprite_w(sprite_w),
		.sprite_x_mirror(sprite_x_mirror),
		.sprite_fg_prio(sprite_fg_prio),
		.sprite_pat(sprite_pat),
		.pixel_x(pixel_x),
		.sprite_ack(sprite_ack),
		.pixel_opaque(pixel_opaque),
		.pixel_index(pixel_index),
		.pixel_palette(pixel_palette),
		.pixel_fg(pixel_fg)
	);

endmodule

`default_nettype wire

/* logic/sprite_unit_chain.sv */
// Sprite slots for one line and the priority pixel lookup
`timescale 1ns/1ns
`default_nettype none

module sprite_unit_chain #(
	parameter int MAX_SPRITES_PER_LINE = 8
) (
	input  logic clock,
	input  logic reset_l,
	input  logic clear,
	input  logic sprite_valid,
	input  logic [7:0] sprite_x,
	input  logic [sprite_pkg::PALETTE_W-1:0] sprite_palette,
	input  logic [1:0] sprite_w,
	input  logic sprite_x_mirror,
	input  logic sprite_fg_prio,
	input  logic [3:0][sprite_pkg::PATTERN_W-1:0] sprite_pat,
	input  logic [7:0] pixel_x,
	output logic sprite_ack,
	output logic pixel_opaque,
	output logic [sprite_pkg::PIXEL_W-1:0] pixel_index,
	output logic [sprite_pkg::PALETTE_W-1:0] pixel_palette,
	output logic pixel_fg
);

	localparam int CNT_W = $clog2(MAX_SPRITES_PER_LINE + 1);
	localparam int IDX_W = (MAX_SPRITES_PER_LINE > 1) ? $clog2(MAX_SPRITES_PER_LINE) : 1;
	localparam logic [CNT_W-1:0] SLOTS = CNT_W'(MAX_SPRITES_PER_LINE);

	logic [MAX_SPRITES_PER_LINE-1:0] slot_valid;
	logic [7:0] slot_x [MAX_SPRITES_PER_LINE];
	logic [1:0] slot_w [MAX_SPRITES_PER_LINE];
	logic slot_xm [MAX_SPRITES_PER_LINE];
	logic [sprite_pkg::PALETTE_W-1:0] slot_pal [MAX_SPRITES_PER_LINE];
	logic slot_fg [MAX_SPRITES_PER_LINE];
	logic [3:0][sprite_pkg::PATTERN_W-1:0] slot_pat [MAX_SPRITES_PER_LINE];

	logic [CNT_W-1:0] slot_count;
	logic [IDX_W-1:0] wr_idx;
	logic full, load;
	logic [MAX_SPRITES_PER_LINE-1:0] slot_hit;
	logic [sprite_pkg::PIXEL_W-1:0] slot_pix [MAX_SPRITES_PER_LINE];

	assign full = (slot_count == SLOTS);
	assign wr_idx = slot_count[IDX_W-1:0];
	assign load = sprite_valid && !sprite_ack && !full; // Ack is held off in the cycle after one

	always_ff @(posedge clock, negedge reset_l) begin
		if (!reset_l) begin
			slot_valid <= '0;
			slot_count <= '0;
			sprite_ack <= 1'b0;
		end else if (clear) begin
			slot_valid <= '0;
			slot_count <= '0;
			sprite_ack <= 1'b0;
		end else begin
			sprite_ack <= load;
			if (load) begin
				slot_valid[wr_idx] <= 1'b1;
				slot_count <= slot_count + 1'b1;
			end
		end
	end

	always_ff @(posedge clock) begin
		if (load) begin
			slot_x[wr_idx] <= sprite_x;
			slot_w[wr_idx] <= sprite_w;
			slot_xm[wr_idx] <= sprite_x_mirror;
			slot_pal[wr_idx] <= sprite_palette;
			slot_fg[wr_idx] <= sprite_fg_prio;
			slot_pat[wr_idx] <= sprite_pat;
		end
	end

	for (genvar i = 0; i < MAX_SPRITES_PER_LINE; i++) begin : g_slot
		logic [8:0] dx;
		logic [5:0] span;
		logic [4:0] pos;
		logic [sprite_pkg::PATTERN_W-1:0] word;

		assign dx = {1'b0, pixel_x} - {1'b0, slot_x[i]};
		assign span = {1'b0, slot_w[i], 3'b000} + 6'd8; // Eight pixels per column
		assign pos = slot_xm[i] ? 5'(span - 6'd1 - dx[5:0]) : dx[4:0];
		assign word = slot_pat[i][pos[4:3]];
		assign slot_pix[i] = word[{pos[2:0], 2'b00} +: sprite_pkg::PIXEL_W];
		assign slot_hit[i] = slot_valid[i] && (dx < {3'b000, span}) && (slot_pix[i] != '0);
	end

	// Walk down so the lowest opaque slot is the one left standing
	always_comb begin
		pixel_opaque = 1'b0;
		pixel_index = '0;
		pixel_palette = '0;
		pixel_fg = 1'b0;
		for (int i = MAX_SPRITES_PER_LINE - 1; i >= 0; i--) begin
			if (slot_hit[i]) begin
				pixel_opaque = 1'b1;
				pixel_index = slot_pix[i];
				pixel_palette = slot_pal[i];
				pixel_fg = slot_fg[i];
			end
		end
	end

	// The manager's sprite limit keeps it from offering a sprite to a full chain
	assert property (@(posedge clock) disable iff (!reset_l)
		!clear && sprite_valid && !sprite_ack |-> !full);

endmodule

`default_nettype wire

/* logic/sprite_manager.sv */
// Sprite fetch FSM that takes configurations, reads patterns and hands sprites on
`timescale 1ns/1ns
`default_nettype none

module sprite_manager #(
	parameter int MAX_SPRITES_PER_LINE = 8
) (
	input  logic clock,
	input  logic reset_l,
	input  logic clear,
	input  logic [7:0] row,
	input  logic [7:0] conf_y,
	input  logic [7:0] conf_x,
	input  logic [7:0] conf_tile,
	input  logic [sprite_pkg::PALETTE_W-1:0] conf_palette,
	input  logic [1:0] conf_w,
	input  logic conf_x_mirror,
	input  logic conf_y_mirror,
	input  logic conf_fg_prio,
	input  logic conf_exists,
	input  logic conf_ack,
	input  logic pattern_avail,
	input  logic [sprite_pkg::PATTERN_W-1:0] pattern_data,
	input  logic sprite_ack,
	output logic ready,
	output logic conf_req,
	output logic pattern_read,
	output logic [sprite_pkg::ADDR_W-1:0] pattern_addr,
	output logic sprite_valid,
	output logic [7:0] sprite_x,
	output logic [sprite_pkg::PALETTE_W-1:0] sprite_palette,
	output logic [1:0] sprite_w,
	output logic sprite_x_mirror,
	output logic sprite_fg_prio,
	output logic [3:0][sprite_pkg::PATTERN_W-1:0] sprite_pat
);

	localparam int CNT_W = $clog2(MAX_SPRITES_PER_LINE + 1);
	localparam logic [CNT_W-1:0] SPR_MAX = CNT_W'(MAX_SPRITES_PER_LINE);

	enum logic [2:0] {CONF_READ, PAT_READ, SEND_SPRITE, SIGNAL, DONE} state, next_state;

	logic [7:0] cur_y, cur_x, cur_tile;
	logic [sprite_pkg::PALETTE_W-1:0] cur_palette;
	logic [1:0] cur_w;
	logic cur_x_mirror, cur_y_mirror, cur_fg_prio;
	logic [3:0][sprite_pkg::PATTERN_W-1:0] pat_buf;

	logic [2:0] req_count, ret_count;
	logic [CNT_W-1:0] sprite_count;
	logic [1:0] flush; // Blocks returns of reads issued before a clear
	logic pat_take;

	sprite_addr_gen u_addr_gen (
		.row(row),
		.conf_y(cur_y),
		.conf_tile(cur_tile),
		.conf_y_mirror(cur_y_mirror),
		.index(req_count[1:0]),
		.addr(pattern_addr)
	);

	assign pat_take = pattern_avail && (flush == 2'd0) && (state == PAT_READ);
	assign sprite_valid = (state == SEND_SPRITE);
	assign ready = (state == SIGNAL) && !clear;

	assign sprite_x = cur_x;
	assign sprite_palette = cur_palette;
	assign sprite_w = cur_w;
	assign sprite_x_mirror = cur_x_mirror;
	assign sprite_fg_prio = cur_fg_prio;
	assign sprite_pat = pat_buf;

	always_comb begin
		next_state = state;
		conf_req = 1'b0;
		pattern_read = 1'b0;
		case (state)
			CONF_READ: begin
				conf_req = conf_exists && (sprite_count < SPR_MAX);
				if (!conf_req) begin
					next_state = SIGNAL; // Scan finished or line full
				end else if (conf_ack) begin
					next_state = PAT_READ;
				end
			end
			PAT_READ: begin
				pattern_read = (req_count <= {1'b0, cur_w});
				if (pat_take && (ret_count == {1'b0, cur_w})) begin
					next_state = SEND_SPRITE;
				end
			end
			SEND_SPRITE: begin
				if (sprite_ack) begin
					next_state = CONF_READ;
				end
			end
			SIGNAL: begin
				next_state = DONE;
			end
			default: begin
				next_state = DONE;
			end
		endcase
		if (clear) begin
			next_state = CONF_READ;
		end
	end

	always_ff @(posedge clock, negedge reset_l) begin
		if (!reset_l) begin
			state <= DONE;
			req_count <= '0;
			ret_count <= '0;
			sprite_count <= '0;
			flush <= 2'd0;
		end else begin
			state <= next_state;
			flush <= clear ? 2'b11 : {1'b0, flush[1]};
			if (clear || (state == CONF_READ)) begin
				req_count <= '0;
				ret_count <= '0;
			end else begin
				if (pattern_read) begin
					req_count <= req_count + 1'b1;
				end
				if (pat_take) begin
					ret_count <= ret_count + 1'b1;
				end
			end
			if (clear) begin
				sprite_count <= '0;
			end else if (sprite_valid && sprite_ack) begin
				sprite_count <= sprite_count + 1'b1;
			end
		end
	end

	always_ff @(posedge clock) begin
		if (conf_req && conf_ack) begin
			cur_y <= conf_y;
			cur_x <= conf_x;
			cur_tile <= conf_tile;
			cur_palette <= conf_palette;
			cur_w <= conf_w;
			cur_x_mirror <= conf_x_mirror;
			cur_y_mirror <= conf_y_mirror;
			cur_fg_prio <= conf_fg_prio;
		end
		if (pat_take) begin
			pat_buf[ret_count[1:0]] <= pattern_data; // Returns arrive in request order
		end
	end

	// All reads of a sprite have returned before it is offered to the chain
	assert property (@(posedge clock) disable iff (!reset_l)
		sprite_valid |-> !(pattern_read || pattern_avail));

endmodule

`default_nettype wire

/* logic/pattern_rom.sv */
// Pattern memory with a two stage read pipeline
`timescale 1ns/1ns
`default_nettype none

module pattern_rom (
	input  logic clock,
	input  logic reset_l,
	input  logic pattern_read,
	input  logic [sprite_pkg::ADDR_W-1:0] pattern_addr,
	output logic pattern_avail,
	output logic [sprite_pkg::PATTERN_W-1:0] pattern_data
);

	logic stage1_valid;
	logic [sprite_pkg::ADDR_W-1:0] stage1_addr;

	always_ff @(posedge clock, negedge reset_l) begin
		if (!reset_l) begin
			stage1_valid <= 1'b0;
			pattern_avail <= 1'b0;
		end else begin
			stage1_valid <= pattern_read;
			pattern_avail <= stage1_valid;
		end
	end

	always_ff @(posedge clock) begin
		stage1_addr <= pattern_addr;
		pattern_data <= sprite_pkg::pattern_word(stage1_addr); // Content generated from address
	end

	assert property (@(posedge clock) disable iff (!reset_l)
		pattern_read |-> ##2 pattern_avail);

	assert property (@(posedge clock) disable iff (!reset_l)
		pattern_avail |-> $past(pattern_read, 2));

endmodule

`default_nettype wire

/* logic/sprite_addr_gen.sv */
// Pattern memory address of one sprite column on the current row
`timescale 1ns/1ns
`default_nettype none

module sprite_addr_gen (
	input  logic [7:0] row,
	input  logic [7:0] conf_y,
	input  logic [7:0] conf_tile,
	input  logic conf_y_mirror,
	input  logic [1:0] index,
	output logic [sprite_pkg::ADDR_W-1:0] addr
);

	logic [7:0] line_full;
	logic [2:0] line;

	assign line_full = sprite_pkg::sprite_line(row, conf_y);
	assign line = conf_y_mirror ? 3'd7 - line_full[2:0] : line_full[2:0]; // Flip vertically

	// Each tile owns 32 words, 8 rows for each of its 4 columns
	assign addr = {conf_tile, index, line};

endmodule

`default_nettype wire

/* logic/oam_scanner.sv */
// OAM storage with host write port and the row hit search feeding the manager
`timescale 1ns/1ns
`default_nettype none

module oam_scanner #(
	parameter int OAM_ENTRIES = 64
) (
	input  logic clock,
	input  logic reset_l,
	input  logic clear,
	input  logic [7:0] row,
	input  logic oam_write,
	input  logic [$clog2(OAM_ENTRIES)-1:0] oam_waddr,
	input  logic [sprite_pkg::OAM_W-1:0] oam_wdata,
	input  logic conf_req,
	output logic conf_exists,
	output logic conf_ack,
	output logic [7:0] conf_y,
	output logic [7:0] conf_x,
	output logic [7:0] conf_tile,
	output logic [sprite_pkg::PALETTE_W-1:0] conf_palette,
	output logic [1:0] conf_w,
	output logic conf_x_mirror,
	output logic conf_y_mirror,
	output logic conf_fg_prio
);

	localparam int IDX_W = $clog2(OAM_ENTRIES);
	localparam logic [IDX_W:0] SCAN_END = (IDX_W + 1)'(OAM_ENTRIES);

	logic [sprite_pkg::OAM_W-1:0] oam_mem [OAM_ENTRIES];
	logic [sprite_pkg::OAM_W-1:0] rd_data;
	logic [sprite_pkg::OAM_W-1:0] hit_data;
	logic [IDX_W:0] scan_idx;
	logic rd_valid, rd_hit, rd_issue;
	logic hit_valid, hit_load, stall;

	assign rd_hit = sprite_pkg::sprite_line(row, rd_data[sprite_pkg::OAM_Y_POS +: 8]) < 8'd8;
	assign stall = rd_valid && rd_hit && hit_valid && !conf_ack; // Hit register still occupied
	assign hit_load = rd_valid && rd_hit && !stall;
	assign rd_issue = !stall && (scan_idx < SCAN_END);

	assign conf_exists = hit_valid || rd_valid || (scan_idx < SCAN_END);
	assign conf_ack = hit_valid && conf_req;

	assign conf_y = hit_data[sprite_pkg::OAM_Y_POS +: 8];
	assign conf_x = hit_data[sprite_pkg::OAM_X_POS +: 8];
	assign conf_tile = hit_data[sprite_pkg::OAM_TILE_POS +: 8];
	assign conf_palette = hit_data[sprite_pkg::OAM_PAL_POS +: sprite_pkg::PALETTE_W];
	assign conf_w = hit_data[sprite_pkg::OAM_W_POS +: 2];
	assign conf_x_mirror = hit_data[sprite_pkg::OAM_XMIR_BIT];
	assign conf_y_mirror = hit_data[sprite_pkg::OAM_YMIR_BIT];
	assign conf_fg_prio = hit_data[sprite_pkg::OAM_FG_BIT];

	always_ff @(posedge clock) begin
		if (oam_write) begin
			oam_mem[oam_waddr] <= oam_wdata;
		end
		if (rd_issue) begin
			rd_data <= oam_mem[scan_idx[IDX_W-1:0]];
		end
		if (hit_load) begin
			hit_data <= rd_data;
		end
	end

	always_ff @(posedge clock, negedge reset_l) begin
		if (!reset_l) begin
			scan_idx <= SCAN_END; // Idle until the first start
			rd_valid <= 1'b0;
			hit_valid <= 1'b0;
		end else if (clear) begin
			scan_idx <= '0;
			rd_valid <= 1'b0;
			hit_valid <= 1'b0;
		end else begin
			if (!stall) begin
				rd_valid <= rd_issue;
				if (rd_issue) begin
					scan_idx <= scan_idx + 1'b1;
				end
			end
			if (hit_load) begin
				hit_valid <= 1'b1;
			end else if (conf_ack) begin
				hit_valid <= 1'b0;
			end
		end
	end

	// The manager drops its request once it has taken a configuration
	assert property (@(posedge clock) disable iff (!reset_l)
		conf_ack |-> conf_req ##1 !conf_ack);

endmodule

`default_nettype wire

/* logic/sprite_pkg.sv */
// Field widths, OAM entry layout and the pattern memory content rule
`default_nettype none

package sprite_pkg;

	localparam int PIXEL_W   = 4;  // Index 0 is transparent
	localparam int PATTERN_W = 32; // Eight pixels, pixel 0 in the low nibble
	localparam int ADDR_W    = 13;
	localparam int PALETTE_W = 3;
	localparam int OAM_W     = 32;

	localparam int OAM_Y_POS    = 0;
	localparam int OAM_X_POS    = 8;
	localparam int OAM_TILE_POS = 16;
	localparam int OAM_PAL_POS  = 24;
	localparam int OAM_W_POS    = 27; // Column count minus one, two bits
	localparam int OAM_XMIR_BIT = 29;
	localparam int OAM_YMIR_BIT = 30;
	localparam int OAM_FG_BIT   = 31;

	// Pixel k holds the low address nibble times 3 plus k, wrapped to four bits
	function automatic logic [PATTERN_W-1:0] pattern_word(input logic [ADDR_W-1:0] addr);
		logic [PATTERN_W-1:0] word;
		logic [PIXEL_W-1:0] base;
		base = addr[3:0] * 4'd3;
		for (int k = 0; k < 8; k++) begin
			word[4*k +: PIXEL_W] = base + 4'(k);
		end
		return word;
	endfunction

	// A value below 8 means the sprite covers the row
	function automatic logic [7:0] sprite_line(input logic [7:0] row, input logic [7:0] y);
		return row - y;
	endfunction

endpackage

`default_nettype wire
